// File: common/ahbPkg.sv
/*
 * Shared definitions for the AHB-Lite subsystem
 *   bus widths and slave slot indices
 *   address map regions and RAM depth
 *   GPIO and timer register offsets
 *   HTRANS and HSIZE codes, address union
 */

`default_nettype none

package ahbPkg;

    localparam int dataWidth = 32;
    localparam int addrWidth = 32;
    localparam int numSlaves = 3;

    // Slots in the select vector
    localparam int slaveRam   = 0;
    localparam int slaveGpio  = 1;
    localparam int slaveTimer = 2;

    // Top four address bits
    localparam logic [3:0] regionRam   = 4'd0;
    localparam logic [3:0] regionGpio  = 4'd1;
    localparam logic [3:0] regionTimer = 4'd2;

    localparam int ramWords = 1024;

    localparam logic [11:0] regGpioOut = 12'd0;
    localparam logic [11:0] regGpioDir = 12'd1;
    localparam logic [11:0] regGpioIn  = 12'd2;

    localparam logic [11:0] regTimLoad   = 12'd0;
    localparam logic [11:0] regTimCount  = 12'd1;
    localparam logic [11:0] regTimCtrl   = 12'd2;
    localparam logic [11:0] regTimStatus = 12'd3;

    localparam logic [1:0] transNonseq = 2'b10;

    localparam logic [2:0] sizeByte = 3'd0;
    localparam logic [2:0] sizeHalf = 3'd1;
    localparam logic [2:0] sizeWord = 3'd2;

    // Raw word, or region / index / byte lane
    typedef union packed {
        logic [addrWidth-1:0] word;
        struct packed {
            logic [3:0]  region;
            logic [13:0] unused;
            logic [11:0] index;
            logic [1:0]  lane;
        } fields;
    } ahbAddrT;

endpackage

`default_nettype wire

// File: design/ahbDecoder.sv
/*
 * AHB-Lite address decoder
 *   one-hot slave select from the address region
 *   unmapped regions select nothing
 */

`timescale 1ns/1ns
`default_nettype none

module ahbDecoder (
    input  ahbPkg::ahbAddrT              hAddr,
    output logic [ahbPkg::numSlaves-1:0] hSel
);

    always_comb begin
        hSel = '0;
        case (hAddr.fields.region)
            ahbPkg::regionRam: begin
                hSel[ahbPkg::slaveRam] = 1'b1;
            end
            ahbPkg::regionGpio: begin
                hSel[ahbPkg::slaveGpio] = 1'b1;
            end
            ahbPkg::regionTimer: begin
                hSel[ahbPkg::slaveTimer] = 1'b1;
            end
            // Anything else is left for the mux to reject
            default: begin
                hSel = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/ahbSlaveMux.sv
/*
 * AHB-Lite slave multiplexer
 *   data-phase select register
 *   read data, ready and response forwarding
 *   two-cycle ERROR response for unmapped transfers
 */

`timescale 1ns/1ns
`default_nettype none

module ahbSlaveMux (
    input  logic                                          HCLK,
    input  logic                                          rstN,
    input  logic [1:0]                                    hTrans,
    input  logic [ahbPkg::numSlaves-1:0]                  hSel,
    input  logic [ahbPkg::numSlaves*ahbPkg::dataWidth-1:0] slaveRData,
    input  logic [ahbPkg::numSlaves-1:0]                  slaveReady,
    input  logic [ahbPkg::numSlaves-1:0]                  slaveResp,
    output logic                                          hReady,
    output logic                                          hResp,
    output logic [ahbPkg::dataWidth-1:0]                  hRData
);

    logic [ahbPkg::numSlaves-1:0] selQ;
    logic                         errPend;
    logic                         errLast;

    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            selQ    <= '0;
            errPend <= 1'b0;
            errLast <= 1'b0;
        end else begin
            if (hReady) begin
                selQ    <= hSel;
                errPend <= (hTrans == ahbPkg::transNonseq) && (hSel == '0);
            end
            // Second ERROR cycle follows the first
            errLast <= errPend && !errLast;
        end
    end

    always_comb begin
        hRData = '0;
        hReady = 1'b1;
        hResp  = 1'b0;
        if (errPend) begin
            hReady = errLast;
            hResp  = 1'b1;
        end else begin
            for (int i = 0; i < ahbPkg::numSlaves; i++) begin
                if (selQ[i]) begin
                    hRData = slaveRData[i*ahbPkg::dataWidth +: ahbPkg::dataWidth];
                    hReady = slaveReady[i];
                    hResp  = slaveResp[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/ahbBlockRam.sv
/*
 * Zero-wait AHB-Lite RAM slave
 *   address-phase capture of index, lane and size
 *   byte enables for byte, halfword and word writes
 *   combinational word read
 */

`timescale 1ns/1ns
`default_nettype none

module ahbBlockRam (
    input  logic                         HCLK,
    input  logic                         rstN,
    input  logic                         hSel,
    input  ahbPkg::ahbAddrT              hAddr,
    input  logic [1:0]                   hTrans,
    input  logic                         hWrite,
    input  logic [2:0]                   hSize,
    input  logic [ahbPkg::dataWidth-1:0] hWData,
    input  logic                         hReady,
    output logic [ahbPkg::dataWidth-1:0] hRData,
    output logic                         hReadyOut,
    output logic                         hResp
);

    logic [ahbPkg::dataWidth-1:0]         mem [ahbPkg::ramWords];
    logic [$clog2(ahbPkg::ramWords)-1:0]  idxQ;
    logic [1:0]                           laneQ;
    logic [2:0]                           sizeQ;
    logic                                 wrQ;
    logic                                 accept;
    logic [3:0]                           byteEn;

    assign accept = hSel && hReady && (hTrans == ahbPkg::transNonseq);

    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            wrQ <= 1'b0;
        end else begin
            wrQ <= accept && hWrite;
        end
    end

    always_comb begin
        case (sizeQ)
            ahbPkg::sizeByte: byteEn = 4'b0001 << laneQ;
            ahbPkg::sizeHalf: byteEn = laneQ[1] ? 4'b1100 : 4'b0011;
            ahbPkg::sizeWord: byteEn = 4'b1111;
            default:          byteEn = 4'b0000;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            idxQ  <= hAddr.fields.index[$clog2(ahbPkg::ramWords)-1:0];
            laneQ <= hAddr.fields.lane;
            sizeQ <= hSize;
        end
        // Commit enabled lanes at the end of the write data phase
        if (wrQ) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) begin
                    mem[idxQ][b*8 +: 8] <= hWData[b*8 +: 8];
                end
            end
        end
    end

    assign hRData    = mem[idxQ];
    assign hReadyOut = 1'b1;
    assign hResp     = 1'b0;

endmodule

`default_nettype wire

// File: design/ahbGpio.sv
/*
 * AHB-Lite GPIO slave
 *   output and direction registers
 *   two-flop input synchronizer
 *   register read mux
 */

`timescale 1ns/1ns
`default_nettype none

module ahbGpio (
    input  logic                         HCLK,
    input  logic                         rstN,
    input  logic                         hSel,
    input  ahbPkg::ahbAddrT              hAddr,
    input  logic [1:0]                   hTrans,
    input  logic                         hWrite,
    input  logic [2:0]                   hSize,
    input  logic [ahbPkg::dataWidth-1:0] hWData,
    input  logic                         hReady,
    input  logic [ahbPkg::dataWidth-1:0] gpioIn,
    output logic [ahbPkg::dataWidth-1:0] hRData,
    output logic                         hReadyOut,
    output logic                         hResp,
    output logic [ahbPkg::dataWidth-1:0] gpioOut,
    output logic [ahbPkg::dataWidth-1:0] gpioOe
);

    logic [ahbPkg::dataWidth-1:0] inMeta;
    logic [ahbPkg::dataWidth-1:0] inSync;
    logic [11:0]                  idxQ;
    logic                         wrQ;
    logic                         accept;

    assign accept = hSel && hReady && (hTrans == ahbPkg::transNonseq);

    always_ff @(posedge HCLK) begin
        if (accept) begin
            idxQ <= hAddr.fields.index;
        end
    end

    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            wrQ     <= 1'b0;
            gpioOut <= '0;
            gpioOe  <= '0;
            inMeta  <= '0;
            inSync  <= '0;
        end else begin
            // Registers take full-word writes only
            wrQ    <= accept && hWrite && (hSize == ahbPkg::sizeWord);
            inMeta <= gpioIn;
            inSync <= inMeta;
            if (wrQ && (idxQ == ahbPkg::regGpioOut)) begin
                gpioOut <= hWData;
            end
            if (wrQ && (idxQ == ahbPkg::regGpioDir)) begin
                gpioOe <= hWData;
            end
        end
    end

    always_comb begin
        case (idxQ)
            ahbPkg::regGpioOut: hRData = gpioOut;
            ahbPkg::regGpioDir: hRData = gpioOe;
            ahbPkg::regGpioIn:  hRData = inSync;
            default:            hRData = '0;
        endcase
    end

    assign hReadyOut = 1'b1;
    assign hResp     = 1'b0;

endmodule

`default_nettype wire

// File: design/ahbTimer.sv
/*
 * AHB-Lite reload timer slave
 *   load, count, control and status registers
 *   down counter with reload at zero
 *   interrupt from status and interrupt enable
 */

`timescale 1ns/1ns
`default_nettype none

module ahbTimer (
    input  logic                         HCLK,
    input  logic                         rstN,
    input  logic                         hSel,
    input  ahbPkg::ahbAddrT              hAddr,
    input  logic [1:0]                   hTrans,
    input  logic                         hWrite,
    input  logic [2:0]                   hSize,
    input  logic [ahbPkg::dataWidth-1:0] hWData,
    input  logic                         hReady,
    output logic [ahbPkg::dataWidth-1:0] hRData,
    output logic                         hReadyOut,
    output logic                         hResp,
    output logic                         irq
);

    logic [ahbPkg::dataWidth-1:0] loadQ;
    logic [ahbPkg::dataWidth-1:0] countQ;
    logic [1:0]                   ctrlQ;
    logic                         statusQ;
    logic [11:0]                  idxQ;
    logic                         wrQ;
    logic                         accept;

    assign accept = hSel && hReady && (hTrans == ahbPkg::transNonseq);

    always_ff @(posedge HCLK) begin
        if (accept) begin
            idxQ <= hAddr.fields.index;
        end
    end

    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            wrQ     <= 1'b0;
            loadQ   <= '0;
            countQ  <= '0;
            ctrlQ   <= 2'b00;
            statusQ <= 1'b0;
        end else begin
            wrQ <= accept && hWrite && (hSize == ahbPkg::sizeWord);
            // Load write also primes the counter
            if (wrQ && (idxQ == ahbPkg::regTimLoad)) begin
                loadQ  <= hWData;
                countQ <= hWData;
            end else if (wrQ && (idxQ == ahbPkg::regTimCount)) begin
                countQ <= hWData;
            end else if (ctrlQ[0]) begin
                countQ <= (countQ == '0) ? loadQ : countQ - 1'b1;
            end
            if (wrQ && (idxQ == ahbPkg::regTimCtrl)) begin
                ctrlQ <= hWData[1:0];
            end
            if (ctrlQ[0] && (countQ == '0)) begin
                statusQ <= 1'b1;
            end else if (wrQ && (idxQ == ahbPkg::regTimStatus) && hWData[0]) begin
                statusQ <= 1'b0;
            end
        end
    end

    always_comb begin
        case (idxQ)
            ahbPkg::regTimLoad:   hRData = loadQ;
            ahbPkg::regTimCount:  hRData = countQ;
            ahbPkg::regTimCtrl:   hRData = {30'd0, ctrlQ};
            ahbPkg::regTimStatus: hRData = {31'd0, statusQ};
            default:              hRData = '0;
        endcase
    end

    assign irq       = statusQ && ctrlQ[1];
    assign hReadyOut = 1'b1;
    assign hResp     = 1'b0;

endmodule

`default_nettype wire

// File: design/ahbLite.sv
/*
 * AHB-Lite subsystem top level
 *   decoder and slave multiplexer
 *   RAM, GPIO and timer slaves
 */

`timescale 1ns/1ns
`default_nettype none

module ahbLite (
    input  logic                         HCLK,
    input  logic                         rstN,
    input  ahbPkg::ahbAddrT              hAddr,
    input  logic [1:0]                   hTrans,
    input  logic                         hWrite,
    input  logic [2:0]                   hSize,
    input  logic [ahbPkg::dataWidth-1:0] hWData,
    input  logic [ahbPkg::dataWidth-1:0] gpioIn,
    output logic                         hReady,
    output logic [ahbPkg::dataWidth-1:0] hRData,
    output logic                         hResp,
    output logic [ahbPkg::dataWidth-1:0] gpioOut,
    output logic [ahbPkg::dataWidth-1:0] gpioOe,
    output logic                         irq
);

    logic [ahbPkg::numSlaves-1:0]                   hSel;
    logic [ahbPkg::numSlaves-1:0]                   slaveReady;
    logic [ahbPkg::numSlaves-1:0]                   slaveResp;
    logic [ahbPkg::numSlaves*ahbPkg::dataWidth-1:0] slaveRData;

    ahbDecoder uDecoder (
        .hAddr (hAddr),
        .hSel  (hSel)
    );

    ahbSlaveMux uSlaveMux (
        .HCLK       (HCLK),
        .rstN       (rstN),
        .hTrans     (hTrans),
        .hSel       (hSel),
        .slaveRData (slaveRData),
        .slaveReady (slaveReady),
        .slaveResp  (slaveResp),
        .hReady     (hReady),
        .hResp      (hResp),
        .hRData     (hRData)
    );

    ahbBlockRam uRam (
        .HCLK      (HCLK),
        .rstN      (rstN),
        .hSel      (hSel[ahbPkg::slaveRam]),
        .hAddr     (hAddr),
        .hTrans    (hTrans),
        .hWrite    (hWrite),
        .hSize     (hSize),
        .hWData    (hWData),
        .hReady    (hReady),
        .hRData    (slaveRData[ahbPkg::slaveRam*ahbPkg::dataWidth +: ahbPkg::dataWidth]),
        .hReadyOut (slaveReady[ahbPkg::slaveRam]),
        .hResp     (slaveResp[ahbPkg::slaveRam])
    );

    ahbGpio uGpio (
        .HCLK      (HCLK),
        .rstN      (rstN),
        .hSel      (hSel[ahbPkg::slaveGpio]),
        .hAddr     (hAddr),
        .hTrans    (hTrans),
        .hWrite    (hWrite),
        .hSize     (hSize),
        .hWData    (hWData),
        .hReady    (hReady),
        .gpioIn    (gpioIn),
        .hRData    (slaveRData[ahbPkg::slaveGpio*ahbPkg::dataWidth +: ahbPkg::dataWidth]),
        .hReadyOut (slaveReady[ahbPkg::slaveGpio]),
        .hResp     (slaveResp[ahbPkg::slaveGpio]),
        .gpioOut   (gpioOut),
        .gpioOe    (gpioOe)
    );

    ahbTimer uTimer (
        .HCLK      (HCLK),
        .rstN      (rstN),
        .hSel      (hSel[ahbPkg::slaveTimer]),
        .hAddr     (hAddr),
        .hTrans    (hTrans),
        .hWrite    (hWrite),
        .hSize     (hSize),
        .hWData    (hWData),
        .hReady    (hReady),
        .hRData    (slaveRData[ahbPkg::slaveTimer*ahbPkg::dataWidth +: ahbPkg::dataWidth]),
        .hReadyOut (slaveReady[ahbPkg::slaveTimer]),
        .hResp     (slaveResp[ahbPkg::slaveTimer]),
        .irq       (irq)
    );

endmodule

`default_nettype wire

// File: bench/tbClock.sv
/*
 * Testbench clock and reset
 *   HCLK with a 100 ns period
 *   rstN held low for 16 cycles
 */

`timescale 1ns/1ns
`default_nettype none

module tbClock (
    output logic HCLK,
    output logic rstN
);

    initial begin
        HCLK = 1'b0;
        forever #50 HCLK = ~HCLK;
    end

    // Release lines up with the stimulus delay
    initial begin
        rstN = 1'b0;
        repeat (16) @(posedge HCLK);
        #10;
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/tbAhbLite.sv
/*
 * Testbench for the AHB-Lite subsystem
 *   bus write and read tasks with stall detection
 *   compare tasks for data, response and levels
 *   directed tests for reset, RAM, GPIO, timer and unmapped access
 *   watchdog
 */

`timescale 1ns/1ns
`default_nettype none

module tbAhbLite;

    localparam int watchdogCycles = 2000;

    logic                         HCLK;
    logic                         rstN;
    ahbPkg::ahbAddrT              hAddr;
    logic [1:0]                   hTrans;
    logic                         hWrite;
    logic [2:0]                   hSize;
    logic [ahbPkg::dataWidth-1:0] hWData;
    logic [ahbPkg::dataWidth-1:0] gpioIn;
    logic                         hReady;
    logic [ahbPkg::dataWidth-1:0] hRData;
    logic                         hResp;
    logic [ahbPkg::dataWidth-1:0] gpioOut;
    logic [ahbPkg::dataWidth-1:0] gpioOe;
    logic                         irq;
    integer                       seed;
    int                           errors;
    int                           stalls;

    tbClock uClock (
        .HCLK (HCLK),
        .rstN (rstN)
    );

    ahbLite u_ahbLite (
        .HCLK    (HCLK),
        .rstN    (rstN),
        .hAddr   (hAddr),
        .hTrans  (hTrans),
        .hWrite  (hWrite),
        .hSize   (hSize),
        .hWData  (hWData),
        .gpioIn  (gpioIn),
        .hReady  (hReady),
        .hRData  (hRData),
        .hResp   (hResp),
        .gpioOut (gpioOut),
        .gpioOe  (gpioOe),
        .irq     (irq)
    );

    task automatic checkData(input string what, input logic [ahbPkg::dataWidth-1:0] got,
                             input logic [ahbPkg::dataWidth-1:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkResp(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s response is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkLevel(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic ahbPkg::ahbAddrT makeAddr(input logic [3:0] region,
                                                 input logic [11:0] index,
                                                 input logic [1:0] lane);
        ahbPkg::ahbAddrT a;
        a.word          = '0;
        a.fields.region = region;
        a.fields.index  = index;
        a.fields.lane   = lane;
        return a;
    endfunction

    // Bits of the word that a transfer of this size and lane may change
    function automatic logic [31:0] laneMask(input logic [2:0] size, input logic [1:0] lane);
        case (size)
            ahbPkg::sizeByte: laneMask = 32'h0000_00ff << (8 * lane);
            ahbPkg::sizeHalf: laneMask = 32'h0000_ffff << (16 * lane[1]);
            default:          laneMask = 32'hffff_ffff;
        endcase
    endfunction

    // Lands on the falling edge once hReady is high
    task automatic waitReady(input string what);
        int n;
        n = 0;
        @(negedge HCLK);
        while (!hReady && n < 16) begin
            @(negedge HCLK);
            n++;
        end
        if (!hReady) begin
            $display("Bus stalled: hReady stayed low for 16 cycles during the %s", what);
            stalls++;
        end
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge HCLK);
        @(negedge HCLK);
    endtask

    // Returns right after the edge that accepts the address
    task automatic addrPhase(input ahbPkg::ahbAddrT addr, input logic write,
                             input logic [2:0] size);
        @(posedge HCLK);
        #10;
        hAddr  = addr;
        hTrans = ahbPkg::transNonseq;
        hWrite = write;
        hSize  = size;
        waitReady("address phase");
        @(posedge HCLK);
    endtask

    task automatic busWrite(input ahbPkg::ahbAddrT addr, input logic [2:0] size,
                            input logic [31:0] data);
        addrPhase(addr, 1'b1, size);
        #10;
        hTrans = 2'b00;
        hWrite = 1'b0;
        hWData = data;
        waitReady("write data phase");
        checkResp("write", hResp, 1'b0);
    endtask

    task automatic busRead(input ahbPkg::ahbAddrT addr, output logic [31:0] data,
                           output logic resp);
        addrPhase(addr, 1'b0, ahbPkg::sizeWord);
        #10;
        hTrans = 2'b00;
        waitReady("read data phase");
        data = hRData;
        resp = hResp;
    endtask

    // Read address phase overlaps the write data phase
    task automatic writeThenRead(input ahbPkg::ahbAddrT addr, input logic [31:0] data,
                                 output logic [31:0] rdata);
        addrPhase(addr, 1'b1, ahbPkg::sizeWord);
        #10;
        hWData = data;
        hWrite = 1'b0;
        waitReady("write data phase");
        @(posedge HCLK);
        #10;
        hTrans = 2'b00;
        waitReady("read data phase");
        rdata = hRData;
    endtask

    task automatic resetStateTest();
        checkLevel("hReady after reset", hReady, 1'b1);
        checkResp("bus after reset", hResp, 1'b0);
        checkLevel("irq after reset", irq, 1'b0);
        checkData("gpioOut after reset", gpioOut, '0);
        checkData("gpioOe after reset", gpioOe, '0);
    endtask

    task automatic ramWordTest();
        logic [31:0] expData [8];
        logic [31:0] data;
        logic        resp;
        for (int i = 0; i < 8; i++) begin
            expData[i] = $random(seed);
            busWrite(makeAddr(ahbPkg::regionRam, 12'(i * 37 + 5), 2'd0), ahbPkg::sizeWord,
                     expData[i]);
        end
        for (int i = 0; i < 8; i++) begin
            busRead(makeAddr(ahbPkg::regionRam, 12'(i * 37 + 5), 2'd0), data, resp);
            checkData("RAM word", data, expData[i]);
            checkResp("RAM read", resp, 1'b0);
        end
    endtask

    task automatic ramLaneTest();
        logic [31:0] base;
        logic [31:0] byteData;
        logic [31:0] halfData;
        logic [31:0] expWord;
        logic [31:0] data;
        logic        resp;
        base     = $random(seed);
        byteData = $random(seed);
        halfData = $random(seed);
        busWrite(makeAddr(ahbPkg::regionRam, 12'd700, 2'd0), ahbPkg::sizeWord, base);
        busWrite(makeAddr(ahbPkg::regionRam, 12'd700, 2'd1), ahbPkg::sizeByte, byteData);
        expWord = (base & ~laneMask(ahbPkg::sizeByte, 2'd1))
                | (byteData & laneMask(ahbPkg::sizeByte, 2'd1));
        busWrite(makeAddr(ahbPkg::regionRam, 12'd700, 2'd2), ahbPkg::sizeHalf, halfData);
        expWord = (expWord & ~laneMask(ahbPkg::sizeHalf, 2'd2))
                | (halfData & laneMask(ahbPkg::sizeHalf, 2'd2));
        busRead(makeAddr(ahbPkg::regionRam, 12'd700, 2'd0), data, resp);
        checkData("RAM after byte and halfword writes", data, expWord);
        base = $random(seed);
        writeThenRead(makeAddr(ahbPkg::regionRam, 12'd701, 2'd0), base, data);
        checkData("RAM read right after write", data, base);
    endtask

    task automatic gpioTest();
        logic [31:0] outVal;
        logic [31:0] dirVal;
        logic [31:0] inVal;
        logic [31:0] data;
        logic        resp;
        outVal = $random(seed);
        dirVal = $random(seed);
        inVal  = $random(seed);
        busWrite(makeAddr(ahbPkg::regionGpio, ahbPkg::regGpioOut, 2'd0), ahbPkg::sizeWord, outVal);
        busWrite(makeAddr(ahbPkg::regionGpio, ahbPkg::regGpioDir, 2'd0), ahbPkg::sizeWord, dirVal);
        waitCycles(1);
        checkData("gpioOut pins", gpioOut, outVal);
        checkData("gpioOe pins", gpioOe, dirVal);
        busRead(makeAddr(ahbPkg::regionGpio, ahbPkg::regGpioOut, 2'd0), data, resp);
        checkData("GPIO out register", data, outVal);
        busRead(makeAddr(ahbPkg::regionGpio, ahbPkg::regGpioDir, 2'd0), data, resp);
        checkData("GPIO dir register", data, dirVal);
        @(posedge HCLK);
        #10;
        gpioIn = inVal;
        // Two synchronizer flops in front of the register
        waitCycles(3);
        busRead(makeAddr(ahbPkg::regionGpio, ahbPkg::regGpioIn, 2'd0), data, resp);
        checkData("GPIO in register", data, inVal);
    endtask

    task automatic timerTest();
        logic [31:0] loadVal;
        logic [31:0] data;
        logic [31:0] first;
        logic        resp;
        int          n;
        loadVal = 32'd20;
        busWrite(makeAddr(ahbPkg::regionTimer, ahbPkg::regTimLoad, 2'd0), ahbPkg::sizeWord,
                 loadVal);
        busWrite(makeAddr(ahbPkg::regionTimer, ahbPkg::regTimCtrl, 2'd0), ahbPkg::sizeWord,
                 32'd3);
        n = 0;
        while (!irq && n < loadVal + 3) begin
            @(negedge HCLK);
            n++;
        end
        if (!irq) begin
            $display("ERROR at %0t ns: irq did not rise within %0d cycles", $time, loadVal + 3);
            errors++;
        end
        busRead(makeAddr(ahbPkg::regionTimer, ahbPkg::regTimStatus, 2'd0), data, resp);
        checkData("timer status with flag set", data, 32'd1);
        busWrite(makeAddr(ahbPkg::regionTimer, ahbPkg::regTimStatus, 2'd0), ahbPkg::sizeWord,
                 32'd1);
        waitCycles(1);
        checkLevel("irq after status clear", irq, 1'b0);
        busWrite(makeAddr(ahbPkg::regionTimer, ahbPkg::regTimCtrl, 2'd0), ahbPkg::sizeWord,
                 32'd0);
        busRead(makeAddr(ahbPkg::regionTimer, ahbPkg::regTimCount, 2'd0), first, resp);
        busRead(makeAddr(ahbPkg::regionTimer, ahbPkg::regTimCount, 2'd0), data, resp);
        checkData("count of stopped timer", data, first);
    endtask

    task automatic unmappedTest();
        logic [31:0] known;
        logic [31:0] data;
        logic        resp;
        known = $random(seed);
        busWrite(makeAddr(ahbPkg::regionRam, 12'd900, 2'd0), ahbPkg::sizeWord, known);
        addrPhase(makeAddr(4'd7, 12'd0, 2'd0), 1'b0, ahbPkg::sizeWord);
        #10;
        hTrans = 2'b00;
        @(negedge HCLK);
        checkLevel("hReady in first ERROR cycle", hReady, 1'b0);
        checkResp("first ERROR cycle", hResp, 1'b1);
        @(negedge HCLK);
        checkLevel("hReady in second ERROR cycle", hReady, 1'b1);
        checkResp("second ERROR cycle", hResp, 1'b1);
        busRead(makeAddr(ahbPkg::regionRam, 12'd900, 2'd0), data, resp);
        checkResp("RAM read after ERROR", resp, 1'b0);
        checkData("RAM read after ERROR", data, known);
    endtask

    initial begin
        seed   = 56;
        errors = 0;
        stalls = 0;
        hAddr  = '0;
        hTrans = 2'b00;
        hWrite = 1'b0;
        hSize  = ahbPkg::sizeWord;
        hWData = '0;
        gpioIn = '0;
        @(posedge rstN);
        @(negedge HCLK);
        resetStateTest();
        ramWordTest();
        ramLaneTest();
        gpioTest();
        timerTest();
        unmappedTest();
        @(posedge HCLK);
        $display("Checks done with %0d errors and %0d stalls", errors, stalls);
        if (errors == 0 && stalls == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge HCLK);
        $display("Watchdog expired because the tests ran past %0d clock cycles", watchdogCycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
common/ahbPkg.sv
design/ahbDecoder.sv
design/ahbSlaveMux.sv
design/ahbBlockRam.sv
design/ahbGpio.sv
design/ahbTimer.sv
design/ahbLite.sv
bench/tbClock.sv
bench/tbAhbLite.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = tbAhbLite
FLIST = list.f

BIN  = obj_dir/V$(TOP)
SRCS = $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
